/* build.f */
+incdir+source
source/yolo_cfg_pkg.sv
source/yolo_bus_pkg.sv
source/cfg_decode.sv
source/pixel_execute.sv
source/maxpool_result.sv
source/mem_writer.sv
source/yolo_write.sv
bench/yolo_write_checker.sv
bench/tb_yolo_write.sv

/* Makefile */
# simulator and build settings, override on the command line
VERILATOR ?= verilator
TOP       ?= tb_yolo_write
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -Wno-fatal
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   list these targets"

# pass only when the run prints the pass line
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* bench/tb_yolo_write.sv */
`include "yolo_write_config.svh"

module tb_yolo_write;
   timeunit 1ns;
   timeprecision 1ps;
   import yolo_cfg_pkg::*;
   import yolo_bus_pkg::*;

   localparam int N_ROWS = 5;
   localparam int MAX_W  = 16;

   typedef struct packed {
      layer_cfg_t cfg;
      logic       rnd;
   } row_t;

   logic                         clk;
   logic                         rst;
   logic                         run;
   logic                         done;
   logic                         pix_ready;
   wb_req_t                      cfg_req;
   wb_rsp_t                      cfg_rsp;
   wb_req_t                      mem_req;
   wb_rsp_t                      mem_rsp;
   pix_t                         pix_in;
   row_t                         rows [N_ROWS];
   layer_cfg_t                   job_cfg;
   logic signed [`YW_DATA_W-1:0] in_vals [4*MAX_W];
   logic [`YW_DATA_W-1:0]        exp_words [MAX_W];
   logic [`YW_DATA_W-1:0]        rd_exp;
   logic                         rd_check;
   logic                         timed_out;
   int                           limit;
   int                           ack_wait;
   int                           err_count;
   int                           check_count;
   int                           tests_done;

   yolo_write i_yolo_write (.*);

   yolo_write_checker #(.MAX_W(MAX_W)) i_checker (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // bias, scale, then leaky slope on negatives
   function automatic logic signed [`YW_DATA_W-1:0] model_value(
      input logic signed [`YW_DATA_W-1:0] acc, input layer_cfg_t c);
      logic signed [`YW_DATA_W-1:0] v;
      v = acc;
      if (c.bias_en)
         v = v + $signed(c.bias);
      v = v >>> c.shift;
      if (c.leaky_en && v < 0)
         v = v >>> `YW_LEAKY_SHIFT;
      return v;
   endfunction

   function automatic int input_count(input layer_cfg_t c);
      return c.maxpool_en ? `YW_POOL_N * int'(c.len) : int'(c.len);
   endfunction

   task automatic prepare_test(input int r);
      logic signed [`YW_DATA_W-1:0] best;
      logic signed [`YW_DATA_W-1:0] v;
      job_cfg = rows[r].cfg;
      for (int i = 0; i < input_count(job_cfg); i++) begin
         if (rows[r].rnd)
            in_vals[i] = $urandom;
         else
            in_vals[i] = (i % 3 == 1) ? -(i * 1000 + 77) : i * 900 + 5;
      end
      for (int w = 0; w < int'(job_cfg.len); w++) begin
         if (job_cfg.maxpool_en) begin
            best = model_value(in_vals[`YW_POOL_N*w], job_cfg);
            for (int k = 1; k < `YW_POOL_N; k++) begin
               v = model_value(in_vals[`YW_POOL_N*w+k], job_cfg);
               if (v > best)
                  best = v;
            end
            exp_words[w] = best;
         end else begin
            exp_words[w] = model_value(in_vals[w], job_cfg);
         end
      end
   endtask

   task automatic cfg_access(input logic we, input cfg_reg_e a, input logic [31:0] d);
      @(negedge clk);
      cfg_req.cyc = 1'b1;
      cfg_req.stb = 1'b1;
      cfg_req.we  = we;
      cfg_req.adr = a;
      cfg_req.dat = d;
      cfg_req.sel = '1;
      @(negedge clk);
      while (!cfg_rsp.ack)
         @(negedge clk);
      cfg_req.cyc = 1'b0;
      cfg_req.stb = 1'b0;
      cfg_req.we  = 1'b0;
   endtask

   task automatic read_check(input cfg_reg_e a, input logic [31:0] want);
      @(negedge clk);
      rd_exp   = want;
      rd_check = 1'b1;
      cfg_access(1'b0, a, '0);
      @(negedge clk);
      rd_check = 1'b0;
   endtask

   // junk in the upper bits must not read back
   task automatic program_bank(input layer_cfg_t c);
      logic [31:0] flags;
      flags = {29'b0, c.maxpool_en, c.leaky_en, c.bias_en};
      cfg_access(1'b1, CFG_EXT_ADDR, c.ext_addr);
      cfg_access(1'b1, CFG_LEN, 32'hbeef_0000 | 32'(c.len));
      cfg_access(1'b1, CFG_SHIFT, 32'hffff_ffe0 | 32'(c.shift));
      cfg_access(1'b1, CFG_BIAS, c.bias);
      cfg_access(1'b1, CFG_CTRL, 32'hffff_fff8 | flags);
      read_check(CFG_EXT_ADDR, c.ext_addr);
      read_check(CFG_LEN, 32'(c.len));
      read_check(CFG_SHIFT, 32'(c.shift));
      read_check(CFG_BIAS, c.bias);
      read_check(CFG_CTRL, flags);
   endtask

   task automatic stream_inputs(input int n);
      @(negedge clk);
      for (int i = 0; i < n; i++) begin
         pix_in.valid = 1'b1;
         pix_in.data  = in_vals[i];
         while (!pix_ready)
            @(negedge clk);
         @(negedge clk);
      end
      pix_in.valid = 1'b0;
   endtask

   // memory slave with a random ack delay of 0 to 3 cycles
   always @(negedge clk) begin
      if (mem_rsp.ack) begin
         mem_rsp.ack = 1'b0;
      end else if (mem_req.cyc && mem_req.stb) begin
         if (ack_wait == 0) begin
            mem_rsp.ack = 1'b1;
            ack_wait    = $urandom_range(3, 0);
         end else begin
            ack_wait--;
         end
      end
   end

   initial begin
      wait (timed_out === 1'b1);
      $display("timeout: done missing after %0d cycles, %0d of %0d tests finished",
               limit, tests_done, N_ROWS);
      $display("*** TEST FAILED ***");
      $finish;
   end

   initial begin
      void'($urandom(32'h7dda_916b));
      // ext_addr, len, shift, bias, bias_en, leaky_en, maxpool_en, random values
      rows[0] = '{'{32'h1000_0000, 16'd8, 5'd4, 32'sd100, 1'b1, 1'b0, 1'b0}, 1'b0};
      rows[1] = '{'{32'h2000_0040, 16'd12, 5'd2, -32'sd50, 1'b1, 1'b1, 1'b0}, 1'b0};
      rows[2] = '{'{32'h3000_0000, 16'd8, 5'd3, 32'sd7, 1'b0, 1'b1, 1'b1}, 1'b1};
      rows[3] = '{'{32'h4000_0100, 16'd16, 5'd0, 32'sh1234, 1'b1, 1'b1, 1'b0}, 1'b1};
      rows[4] = '{'{32'h5000_0000, 16'd6, 5'd7, -32'sd9, 1'b1, 1'b0, 1'b1}, 1'b0};
      limit = 200;
      for (int r = 0; r < N_ROWS; r++)
         limit += 10 * input_count(rows[r].cfg);
      rst      = 1'b1;
      run      = 1'b0;
      cfg_req  = '0;
      pix_in   = '0;
      mem_rsp  = '0;
      rd_check = 1'b0;
      rd_exp   = '0;
      ack_wait = 0;
      job_cfg  = '0;
      foreach (exp_words[i])
         exp_words[i] = '0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      program_bank(rows[0].cfg);
      for (int r = 0; r < N_ROWS; r++) begin
         prepare_test(r);
         @(negedge clk);
         run = 1'b1;
         @(negedge clk);
         run = 1'b0;
         // next layer goes into the bank while this one runs
         fork
            stream_inputs(input_count(rows[r].cfg));
            begin
               if (r + 1 < N_ROWS)
                  program_bank(rows[r+1].cfg);
            end
         join
         while (!done)
            @(negedge clk);
         @(negedge clk);
      end
      repeat (2) @(negedge clk);
      $display("tests %0d of %0d, checks %0d, errors %0d",
               tests_done, N_ROWS, check_count, err_count);
      if (err_count == 0 && tests_done == N_ROWS) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

/* bench/yolo_write_checker.sv */
`include "yolo_write_config.svh"

module yolo_write_checker #(
   parameter int MAX_W = 16
) (
   input  logic                     clk,
   input  logic                     rst,
   input  yolo_bus_pkg::wb_req_t    mem_req,
   input  yolo_bus_pkg::wb_rsp_t    mem_rsp,
   input  yolo_bus_pkg::wb_rsp_t    cfg_rsp,
   input  logic                     done,
   input  logic                     pix_ready,
   input  logic                     run,
   input  yolo_cfg_pkg::layer_cfg_t job_cfg,
   input  logic [`YW_DATA_W-1:0]    exp_words [MAX_W],
   input  logic                     rd_check,
   input  logic [`YW_DATA_W-1:0]    rd_exp,
   input  int                       limit,
   output logic                     timed_out,
   output int                       err_count,
   output int                       check_count,
   output int                       tests_done
);
   timeunit 1ns;
   timeprecision 1ps;

   int                    word_idx;
   int                    test_id;
   int                    err_base;
   int                    cycles;
   logic                  done_q;
   logic                  job_on;
   logic [`YW_ADDR_W-1:0] exp_adr;

   always @(posedge clk or posedge rst) begin
      if (rst) begin
         timed_out   = 1'b0;
         err_count   = 0;
         check_count = 0;
         tests_done  = 0;
         word_idx    = 0;
         test_id     = -1;
         err_base    = 0;
         cycles      = 0;
         done_q      = 1'b0;
         job_on      = 1'b0;
      end else begin
         cycles++;
         if (cycles >= limit)
            timed_out = 1'b1;
         // rising done closes the job
         if (done && !done_q) begin
            if (word_idx != int'(job_cfg.len)) begin
               $display("test %0d: done rose after %0d of %0d writes",
                        test_id, word_idx, job_cfg.len);
               err_count++;
            end
            tests_done++;
            job_on = 1'b0;
            $display("test %0d finished: %0d writes, %0d errors",
                     test_id, word_idx, err_count - err_base);
         end
         done_q = done;
         if (run) begin
            test_id++;
            word_idx = 0;
            err_base = err_count;
            job_on   = 1'b1;
         end
         // input side stays closed between jobs
         if (pix_ready && !job_on) begin
            $display("ERROR %0t: pix_ready high while no job is running", $time);
            err_count++;
         end
         if (mem_req.cyc && mem_req.stb && mem_rsp.ack) begin
            if (word_idx >= int'(job_cfg.len)) begin
               $display("test %0d: extra write to address %h after %0d words",
                        test_id, mem_req.adr, word_idx);
               err_count++;
            end else begin
               exp_adr = job_cfg.ext_addr + 32'(4 * word_idx);
               check_count++;
               if (mem_req.adr !== exp_adr || mem_req.dat !== exp_words[word_idx] ||
                   mem_req.we !== 1'b1 || mem_req.sel !== '1) begin
                  $display("ERROR %0t: test %0d write %0d adr %h dat %h, expected %h %h",
                           $time, test_id, word_idx, mem_req.adr, mem_req.dat,
                           exp_adr, exp_words[word_idx]);
                  err_count++;
               end
            end
            word_idx++;
         end
         if (rd_check && cfg_rsp.ack) begin
            check_count++;
            if (cfg_rsp.dat !== rd_exp) begin
               $display("ERROR %0t: register readback %h, expected %h",
                        $time, cfg_rsp.dat, rd_exp);
               err_count++;
            end
         end
      end
   end

endmodule

/* source/yolo_write.sv */
`include "yolo_write_config.svh"

module yolo_write (
   input  logic                  clk,
   input  logic                  rst,
   input  yolo_bus_pkg::wb_req_t cfg_req,
   output yolo_bus_pkg::wb_rsp_t cfg_rsp,
   input  logic                  run,
   output logic                  done,
   input  yolo_bus_pkg::pix_t    pix_in,
   output logic                  pix_ready,
   output yolo_bus_pkg::wb_req_t mem_req,
   input  yolo_bus_pkg::wb_rsp_t mem_rsp
);
   import yolo_cfg_pkg::*;
   import yolo_bus_pkg::*;

   layer_cfg_t cfg;
   logic       start;
   logic       job_end;
   pix_t       exec_out;
   logic       exec_ready;
   pix_t       pool_out;
   logic       pool_ready;

   cfg_decode i_cfg_decode (
      .clk     (clk),
      .rst     (rst),
      .cfg_req (cfg_req),
      .run     (run),
      .job_end (job_end),
      .cfg_rsp (cfg_rsp),
      .cfg     (cfg),
      .start   (start),
      .done    (done)
   );

   pixel_execute i_pixel_execute (
      .clk       (clk),
      .rst       (rst),
      .cfg       (cfg),
      .pix_in    (pix_in),
      .out_ready (exec_ready),
      .in_ready  (pix_ready),
      .exec_out  (exec_out)
   );

   maxpool_result i_maxpool_result (
      .clk       (clk),
      .rst       (rst),
      .cfg       (cfg),
      .start     (start),
      .in        (exec_out),
      .out_ready (pool_ready),
      .in_ready  (exec_ready),
      .pool_out  (pool_out)
   );

   mem_writer i_mem_writer (
      .clk      (clk),
      .rst      (rst),
      .cfg      (cfg),
      .start    (start),
      .in       (pool_out),
      .mem_rsp  (mem_rsp),
      .in_ready (pool_ready),
      .mem_req  (mem_req),
      .job_end  (job_end)
   );

endmodule

/* source/mem_writer.sv */
`include "yolo_write_config.svh"

module mem_writer (
   input  logic                     clk,
   input  logic                     rst,
   input  yolo_cfg_pkg::layer_cfg_t cfg,
   input  logic                     start,
   input  yolo_bus_pkg::pix_t       in,
   input  yolo_bus_pkg::wb_rsp_t    mem_rsp,
   output logic                     in_ready,
   output yolo_bus_pkg::wb_req_t    mem_req,
   output logic                     job_end
);

   typedef enum logic {
      WR_IDLE,
      WR_BUS
   } wr_state_e;

   wr_state_e             state;
   logic [`YW_LEN_W-1:0]  count;
   logic [`YW_LEN_W-1:0]  count_nxt;
   logic [`YW_ADDR_W-1:0] wr_adr;
   logic [`YW_DATA_W-1:0] wr_dat;
   logic                  take;
   logic                  bus_done;

   assign count_nxt = count + 1'b1;
   // closed once len words are out
   assign in_ready  = (state == WR_IDLE) && (count != cfg.len) && !start;
   assign take      = in_ready && in.valid;
   assign bus_done  = (state == WR_BUS) && mem_rsp.ack;
   // empty job ends right at start
   assign job_end   = (bus_done && count_nxt == cfg.len) || (start && cfg.len == '0);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= WR_IDLE;
         count <= '0;
      end else begin
         if (start)
            count <= '0;
         case (state)
            WR_IDLE: begin
               if (take)
                  state <= WR_BUS;
            end
            WR_BUS: begin
               if (mem_rsp.ack) begin
                  state <= WR_IDLE;
                  count <= count_nxt;
               end
            end
            default: state <= WR_IDLE;
         endcase
      end
   end

   // byte address of word count
   always_ff @(posedge clk) begin
      if (take) begin
         wr_adr <= cfg.ext_addr + {{(`YW_ADDR_W - `YW_LEN_W - 2){1'b0}}, count, 2'b00};
         wr_dat <= in.data;
      end
   end

   always_comb begin
      mem_req.cyc = (state == WR_BUS);
      mem_req.stb = (state == WR_BUS);
      mem_req.we  = 1'b1;
      mem_req.adr = wr_adr;
      mem_req.dat = wr_dat;
      mem_req.sel = '1;
   end

endmodule

/* source/maxpool_result.sv */
`include "yolo_write_config.svh"

module maxpool_result (
   input  logic                     clk,
   input  logic                     rst,
   input  yolo_cfg_pkg::layer_cfg_t cfg,
   input  logic                     start,
   input  yolo_bus_pkg::pix_t       in,
   input  logic                     out_ready,
   output logic                     in_ready,
   output yolo_bus_pkg::pix_t       pool_out
);

   localparam int CNT_W = $clog2(`YW_POOL_N);

   logic                         advance;
   logic                         take;
   logic                         last;
   logic [CNT_W-1:0]             grp_cnt;
   logic signed [`YW_DATA_W-1:0] run_max;
   logic signed [`YW_DATA_W-1:0] cur_max;
   logic                         out_valid;
   logic signed [`YW_DATA_W-1:0] out_data;

   assign advance  = out_ready;
   assign in_ready = advance;
   assign take     = advance && in.valid;
   assign last     = (grp_cnt == CNT_W'(`YW_POOL_N - 1));

   // first value of a group starts a fresh maximum
   assign cur_max = (grp_cnt == '0 || in.data > run_max) ? in.data : run_max;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         grp_cnt   <= '0;
         out_valid <= 1'b0;
      end else begin
         if (start)
            grp_cnt <= '0;
         else if (take && cfg.maxpool_en)
            grp_cnt <= last ? '0 : grp_cnt + 1'b1;
         // pass mode emits every value
         if (advance)
            out_valid <= in.valid && (!cfg.maxpool_en || last);
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         run_max  <= cur_max;
         out_data <= cfg.maxpool_en ? cur_max : in.data;
      end
   end

   always_comb begin
      pool_out.valid = out_valid;
      pool_out.data  = out_data;
   end

endmodule

/* source/pixel_execute.sv */
`include "yolo_write_config.svh"

module pixel_execute (
   input  logic                     clk,
   input  logic                     rst,
   input  yolo_cfg_pkg::layer_cfg_t cfg,
   input  yolo_bus_pkg::pix_t       pix_in,
   input  logic                     out_ready,
   output logic                     in_ready,
   output yolo_bus_pkg::pix_t       exec_out
);

   logic                         advance;
   logic signed [`YW_DATA_W-1:0] biased;
   logic signed [`YW_DATA_W-1:0] scaled;
   logic signed [`YW_DATA_W-1:0] activated;
   logic                         s1_valid;
   logic signed [`YW_DATA_W-1:0] s1_data;
   logic                         s2_valid;
   logic signed [`YW_DATA_W-1:0] s2_data;

   // output stall freezes both stages
   assign advance  = out_ready;
   assign in_ready = advance;

   // stage 1 bias then scale
   always_comb begin
      biased = pix_in.data;
      if (cfg.bias_en)
         biased = pix_in.data + cfg.bias;
      scaled = biased >>> cfg.shift;
   end

   // stage 2 leaky relu, negatives only
   always_comb begin
      activated = s1_data;
      if (cfg.leaky_en && s1_data[`YW_DATA_W-1])
         activated = s1_data >>> `YW_LEAKY_SHIFT;
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         s1_valid <= 1'b0;
         s2_valid <= 1'b0;
      end else if (advance) begin
         s1_valid <= pix_in.valid;
         s2_valid <= s1_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (advance) begin
         s1_data <= scaled;
         s2_data <= activated;
      end
   end

   always_comb begin
      exec_out.valid = s2_valid;
      exec_out.data  = s2_data;
   end

endmodule

/* source/cfg_decode.sv */
`include "yolo_write_config.svh"

module cfg_decode (
   input  logic                     clk,
   input  logic                     rst,
   input  yolo_bus_pkg::wb_req_t    cfg_req,
   input  logic                     run,
   input  logic                     job_end,
   output yolo_bus_pkg::wb_rsp_t    cfg_rsp,
   output yolo_cfg_pkg::layer_cfg_t cfg,
   output logic                     start,
   output logic                     done
);
   import yolo_cfg_pkg::*;

   layer_cfg_t            bank;
   cfg_reg_e              reg_sel;
   logic                  access;
   logic                  run_ok;
   logic                  busy;
   logic                  ack_q;
   logic [`YW_DATA_W-1:0] rd_data;
   logic [`YW_DATA_W-1:0] rd_q;

   assign reg_sel = cfg_reg_e'(cfg_req.adr[`YW_CFG_ADDR_W-1:0]);
   // one access per strobe, ack closes it
   assign access  = cfg_req.cyc && cfg_req.stb && !ack_q;
   assign run_ok  = run && !busy;

   always_comb begin
      rd_data = '0;
      case (reg_sel)
         CFG_EXT_ADDR: rd_data[`YW_ADDR_W-1:0]  = bank.ext_addr;
         CFG_LEN:      rd_data[`YW_LEN_W-1:0]   = bank.len;
         CFG_SHIFT:    rd_data[`YW_SHIFT_W-1:0] = bank.shift;
         CFG_BIAS:     rd_data                  = bank.bias;
         CFG_CTRL: begin
            rd_data[CTRL_BIAS_BIT]    = bank.bias_en;
            rd_data[CTRL_LEAKY_BIT]   = bank.leaky_en;
            rd_data[CTRL_MAXPOOL_BIT] = bank.maxpool_en;
         end
         default:      rd_data = '0;
      endcase
   end

   // working bank, writable at any time
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         bank <= '0;
      end else if (access && cfg_req.we) begin
         case (reg_sel)
            CFG_EXT_ADDR: bank.ext_addr <= cfg_req.dat[`YW_ADDR_W-1:0];
            CFG_LEN:      bank.len      <= cfg_req.dat[`YW_LEN_W-1:0];
            CFG_SHIFT:    bank.shift    <= cfg_req.dat[`YW_SHIFT_W-1:0];
            CFG_BIAS:     bank.bias     <= cfg_req.dat;
            CFG_CTRL: begin
               bank.bias_en    <= cfg_req.dat[CTRL_BIAS_BIT];
               bank.leaky_en   <= cfg_req.dat[CTRL_LEAKY_BIT];
               bank.maxpool_en <= cfg_req.dat[CTRL_MAXPOOL_BIT];
            end
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst)
         ack_q <= 1'b0;
      else
         ack_q <= access;
   end

   always_ff @(posedge clk) begin
      if (access && !cfg_req.we)
         rd_q <= rd_data;
   end

   always_comb begin
      cfg_rsp.ack = ack_q;
      cfg_rsp.dat = rd_q;
   end

   // shadow copy and job control
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         cfg   <= '0;
         busy  <= 1'b0;
         start <= 1'b0;
         done  <= 1'b0;
      end else begin
         start <= run_ok;
         if (run_ok) begin
            cfg  <= bank;
            busy <= 1'b1;
            done <= 1'b0;
         end else if (job_end) begin
            busy <= 1'b0;
            done <= 1'b1;
         end
      end
   end

endmodule

/* source/yolo_bus_pkg.sv */
`include "yolo_write_config.svh"

package yolo_bus_pkg;

   // wishbone master to slave
   typedef struct packed {
      logic                      cyc;
      logic                      stb;
      logic                      we;
      logic [`YW_ADDR_W-1:0]     adr;
      logic [`YW_DATA_W-1:0]     dat;
      logic [`YW_DATA_W/8-1:0]   sel;
   } wb_req_t;

   // wishbone slave to master
   typedef struct packed {
      logic                      ack;
      logic [`YW_DATA_W-1:0]     dat;
   } wb_rsp_t;

   // one accumulator value on a stream link
   typedef struct packed {
      logic                      valid;
      logic signed [`YW_DATA_W-1:0] data;
   } pix_t;

endpackage

/* source/yolo_cfg_pkg.sv */
`include "yolo_write_config.svh"

package yolo_cfg_pkg;

   // word addresses on the config port
   typedef enum logic [`YW_CFG_ADDR_W-1:0] {
      CFG_EXT_ADDR = '0,
      CFG_LEN,
      CFG_SHIFT,
      CFG_BIAS,
      CFG_CTRL
   } cfg_reg_e;

   // flag positions inside CFG_CTRL
   localparam int CTRL_BIAS_BIT    = 0;
   localparam int CTRL_LEAKY_BIT   = 1;
   localparam int CTRL_MAXPOOL_BIT = 2;

   // settings held for one layer
   typedef struct packed {
      logic [`YW_ADDR_W-1:0]        ext_addr;
      logic [`YW_LEN_W-1:0]         len;
      logic [`YW_SHIFT_W-1:0]       shift;
      logic signed [`YW_DATA_W-1:0] bias;
      logic                         bias_en;
      logic                         leaky_en;
      logic                         maxpool_en;
   } layer_cfg_t;

endpackage

/* source/yolo_write_config.svh */
`ifndef YOLO_WRITE_CONFIG_SVH
`define YOLO_WRITE_CONFIG_SVH

// data and bus widths
`define YW_DATA_W      32
`define YW_ADDR_W      32

// config port word address
`define YW_CFG_ADDR_W  3

// layer settings
`define YW_SHIFT_W     5
`define YW_LEN_W       16

// leaky relu slope as a right shift
`define YW_LEAKY_SHIFT 3

// 2x2 window flattened to a run of values
`define YW_POOL_N      4

`endif
